/* list.f */
rtl/cache_demux_pkg.sv
rtl/req_demux.sv
rtl/rsp_arbiter.sv
rtl/rsp_mux.sv
rtl/cache_demux.sv
tb/cache_demux_chk.sv
tb/cache_demux_tb.sv

/* rtl/cache_demux.sv */
`timescale 1ns/1ps

module cache_demux import cache_demux_pkg::*; (
    input  logic                     clk,
    input  logic                     rst_n,

    // Client request.
    input  logic                     req_valid,
    input  tag_in_t                  req_tag,
    input  addr_t                    req_addr,
    input  logic                     req_rw,
    input  byteen_t                  req_byteen,
    input  data_t                    req_data,
    output logic                     req_ready,

    // Bank requests.
    output req_mask_t                bank_req_valid,
    output tag_out_t [NUM_REQS-1:0]  bank_req_tag,
    output addr_t    [NUM_REQS-1:0]  bank_req_addr,
    output logic     [NUM_REQS-1:0]  bank_req_rw,
    output byteen_t  [NUM_REQS-1:0]  bank_req_byteen,
    output data_t    [NUM_REQS-1:0]  bank_req_data,
    input  req_mask_t                bank_req_ready,

    // Bank responses.
    input  req_mask_t                bank_rsp_valid,
    input  tag_out_t [NUM_REQS-1:0]  bank_rsp_tag,
    input  data_t    [NUM_REQS-1:0]  bank_rsp_data,
    output req_mask_t                bank_rsp_ready,

    // Client response.
    output logic                     rsp_valid,
    output tag_in_t                  rsp_tag,
    output data_t                    rsp_data,
    input  logic                     rsp_ready
);

    tag_out_t  demux_tag;
    addr_t     demux_addr;
    logic      demux_rw;
    byteen_t   demux_byteen;
    data_t     demux_data;

    req_mask_t grant;
    sel_t      grant_idx;
    logic      slot_free;

    req_demux u_req_demux (
        .clk        (clk),
        .rst_n      (rst_n),
        .in_valid   (req_valid),
        .in_tag     (req_tag),
        .in_addr    (req_addr),
        .in_rw      (req_rw),
        .in_byteen  (req_byteen),
        .in_data    (req_data),
        .in_ready   (req_ready),
        .out_valid  (bank_req_valid),
        .out_tag    (demux_tag),
        .out_addr   (demux_addr),
        .out_rw     (demux_rw),
        .out_byteen (demux_byteen),
        .out_data   (demux_data),
        .out_ready  (bank_req_ready)
    );

    // One payload register feeds every bank.
    for (genvar i = 0; i < NUM_REQS; i++) begin : g_bank
        assign bank_req_tag[i]    = demux_tag;
        assign bank_req_addr[i]   = demux_addr;
        assign bank_req_rw[i]     = demux_rw;
        assign bank_req_byteen[i] = demux_byteen;
        assign bank_req_data[i]   = demux_data;
    end

    rsp_arbiter u_rsp_arbiter (
        .clk        (clk),
        .rst_n      (rst_n),
        .bank_valid (bank_rsp_valid),
        .slot_free  (slot_free),
        .grant      (grant),
        .grant_idx  (grant_idx)
    );

    assign bank_rsp_ready = grant;   // Granted bank pops.

    rsp_mux u_rsp_mux (
        .clk        (clk),
        .rst_n      (rst_n),
        .grant      (grant),
        .grant_idx  (grant_idx),
        .bank_tag   (bank_rsp_tag),
        .bank_data  (bank_rsp_data),
        .slot_free  (slot_free),
        .out_valid  (rsp_valid),
        .out_tag    (rsp_tag),
        .out_data   (rsp_data),
        .out_ready  (rsp_ready)
    );

endmodule

/* rtl/cache_demux_pkg.sv */
package cache_demux_pkg;

    // Bank count and select field.
    localparam int NUM_REQS      = 4;
    localparam int LOG_NUM_REQS  = 2;

    // Tag layout.
    localparam int TAG_IN_WIDTH  = 8;
    localparam int TAG_SEL_IDX   = 0;   // Select field starts here.
    localparam int TAG_OUT_WIDTH = TAG_IN_WIDTH - LOG_NUM_REQS;

    // Word geometry.
    localparam int DATA_SIZE     = 4;   // Bytes per word.
    localparam int DATA_WIDTH    = 8 * DATA_SIZE;
    localparam int ADDR_WIDTH    = 32 - LOG_NUM_REQS;   // Word address.

    // Upstream tag, select bits included.
    typedef logic [TAG_IN_WIDTH-1:0]  tag_in_t;

    // Bank side tag, select bits removed.
    typedef logic [TAG_OUT_WIDTH-1:0] tag_out_t;

    // Bank index.
    typedef logic [LOG_NUM_REQS-1:0]  sel_t;

    typedef logic [ADDR_WIDTH-1:0]    addr_t;

    typedef logic [DATA_WIDTH-1:0]    data_t;

    typedef logic [DATA_SIZE-1:0]     byteen_t;

    // One bit per bank.
    typedef logic [NUM_REQS-1:0]      req_mask_t;

endpackage

/* rtl/req_demux.sv */
`timescale 1ns/1ps

module req_demux import cache_demux_pkg::*; (
    input  logic      clk,
    input  logic      rst_n,

    input  logic      in_valid,
    input  tag_in_t   in_tag,
    input  addr_t     in_addr,
    input  logic      in_rw,
    input  byteen_t   in_byteen,
    input  data_t     in_data,
    output logic      in_ready,

    output req_mask_t out_valid,
    output tag_out_t  out_tag,
    output addr_t     out_addr,
    output logic      out_rw,
    output byteen_t   out_byteen,
    output data_t     out_data,
    input  req_mask_t out_ready
);

    sel_t      in_sel;
    tag_in_t   low_mask;
    tag_in_t   tag_lo;
    tag_in_t   tag_hi;
    tag_out_t  tag_strip;
    req_mask_t in_target;
    req_mask_t out_mask;
    logic      drain;
    logic      load;

    assign in_sel = in_tag[TAG_SEL_IDX +: LOG_NUM_REQS];   // Bank select field.

    // Close the gap left by the select field.
    assign low_mask  = tag_in_t'((1 << TAG_SEL_IDX) - 1);
    assign tag_lo    = in_tag & low_mask;
    assign tag_hi    = (in_tag >> (TAG_SEL_IDX + LOG_NUM_REQS)) << TAG_SEL_IDX;
    assign tag_strip = tag_out_t'(tag_hi | tag_lo);

    assign in_target = req_mask_t'(1) << in_sel;

    // Slot empties when its bank takes it.
    assign drain    = |(out_mask & out_ready);
    assign in_ready = ~(|out_mask) | drain;
    assign load     = in_valid & in_ready;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            out_mask <= '0;
        end else if (load) begin
            out_mask <= in_target;   // Refill on same edge as drain.
        end else if (drain) begin
            out_mask <= '0;
        end
    end

    always_ff @(posedge clk) begin
        if (load) begin
            out_tag    <= tag_strip;
            out_addr   <= in_addr;
            out_rw     <= in_rw;
            out_byteen <= in_byteen;
            out_data   <= in_data;
        end
    end

    assign out_valid = out_mask;   // Only the target bank sees valid.

endmodule

/* rtl/rsp_arbiter.sv */
`timescale 1ns/1ps

module rsp_arbiter import cache_demux_pkg::*; (
    input  logic      clk,
    input  logic      rst_n,
    input  req_mask_t bank_valid,
    input  logic      slot_free,
    output req_mask_t grant,
    output sel_t      grant_idx
);

    sel_t rr_ptr;   // Last winner.
    sel_t idx;
    logic found;

    // Search starts one past the last winner and ends on it.
    always_comb begin
        grant     = '0;
        grant_idx = '0;
        found     = 1'b0;
        idx       = '0;
        if (slot_free) begin
            for (int i = 1; i <= NUM_REQS; i++) begin
                idx = rr_ptr + sel_t'(i);   // Wraps at NUM_REQS.
                if (!found && bank_valid[idx]) begin
                    found     = 1'b1;
                    grant_idx = idx;
                    grant     = req_mask_t'(1) << idx;
                end
            end
        end
    end

    // A grant is a transfer, so the pointer moves on every grant.
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            rr_ptr <= '0;
        end else if (found) begin
            rr_ptr <= grant_idx;
        end
    end

endmodule

/* rtl/rsp_mux.sv */
`timescale 1ns/1ps

module rsp_mux import cache_demux_pkg::*; (
    input  logic                     clk,
    input  logic                     rst_n,

    input  req_mask_t                grant,
    input  sel_t                     grant_idx,
    input  tag_out_t [NUM_REQS-1:0]  bank_tag,
    input  data_t    [NUM_REQS-1:0]  bank_data,
    output logic                     slot_free,

    output logic                     out_valid,
    output tag_in_t                  out_tag,
    output data_t                    out_data,
    input  logic                     out_ready
);

    tag_in_t  low_mask;
    tag_in_t  sel_tag;
    tag_in_t  tag_full;
    data_t    sel_data;
    logic     accept;

    // Granted bank payload.
    assign sel_tag  = tag_in_t'(bank_tag[grant_idx]);
    assign sel_data = bank_data[grant_idx];

    // Put the bank index back at the select position.
    assign low_mask = tag_in_t'((1 << TAG_SEL_IDX) - 1);
    assign tag_full = ((sel_tag >> TAG_SEL_IDX) << (TAG_SEL_IDX + LOG_NUM_REQS))
                    | (tag_in_t'(grant_idx) << TAG_SEL_IDX)
                    | (sel_tag & low_mask);

    assign accept    = |grant;
    assign slot_free = ~out_valid | out_ready;   // Empty or draining.

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            out_valid <= 1'b0;
        end else if (accept) begin
            out_valid <= 1'b1;
        end else if (out_ready) begin
            out_valid <= 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (accept) begin
            out_tag  <= tag_full;
            out_data <= sel_data;
        end
    end

endmodule

/* run.sh */
#!/bin/sh
# Build the testbench with Verilator and run it from the project root.
# The exit status of the simulation is the result.
cd "$(dirname "$0")" || exit 1
verilator --binary --timing --assert -Wno-fatal \
    --top-module cache_demux_tb -f list.f -o sim_cache_demux \
    && ./obj_dir/sim_cache_demux \
    || exit 1

/* tb/cache_demux_chk.sv */
`timescale 1ns/1ps

module cache_demux_chk import cache_demux_pkg::*; (
    input logic                    clk,
    input logic                    rst_n,
    input logic                    req_ready,
    input req_mask_t               bank_req_valid,
    input req_mask_t               bank_req_ready,
    input tag_out_t [NUM_REQS-1:0] bank_req_tag,
    input addr_t    [NUM_REQS-1:0] bank_req_addr,
    input logic     [NUM_REQS-1:0] bank_req_rw,
    input byteen_t  [NUM_REQS-1:0] bank_req_byteen,
    input data_t    [NUM_REQS-1:0] bank_req_data,
    input req_mask_t               grant,
    input logic                    rsp_valid,
    input logic                    rsp_ready,
    input tag_in_t                 rsp_tag,
    input data_t                   rsp_data
);

    // Stalled bank request keeps target and payload.
    a_bank_req_hold: assert property (@(posedge clk) disable iff (!rst_n)
        |(bank_req_valid & ~bank_req_ready) |=>
            (bank_req_valid == $past(bank_req_valid)) && $stable(bank_req_tag)
            && $stable(bank_req_addr) && $stable(bank_req_rw)
            && $stable(bank_req_byteen) && $stable(bank_req_data))
        else $error("bank request changed while stalled");

    a_rsp_hold: assert property (@(posedge clk) disable iff (!rst_n)
        rsp_valid && !rsp_ready |=> rsp_valid && $stable(rsp_tag) && $stable(rsp_data))
        else $error("upstream response changed while stalled");

    a_grant_onehot: assert property (@(posedge clk) disable iff (!rst_n)
        $onehot0(grant))
        else $error("grant is not one-hot or zero");

    a_bank_req_onehot: assert property (@(posedge clk) disable iff (!rst_n)
        $onehot0(bank_req_valid))
        else $error("more than one bank request valid");

    // No grant while the upstream register is blocked.
    a_grant_slot: assert property (@(posedge clk) disable iff (!rst_n)
        (grant != '0) |-> (!rsp_valid || rsp_ready))
        else $error("grant issued without a free slot");

    a_reset_state: assert property (@(posedge clk)
        !rst_n |-> (bank_req_valid == '0) && !rsp_valid && req_ready)
        else $error("outputs not idle during reset");

endmodule

bind cache_demux cache_demux_chk u_chk (
    .clk             (clk),
    .rst_n           (rst_n),
    .req_ready       (req_ready),
    .bank_req_valid  (bank_req_valid),
    .bank_req_ready  (bank_req_ready),
    .bank_req_tag    (bank_req_tag),
    .bank_req_addr   (bank_req_addr),
    .bank_req_rw     (bank_req_rw),
    .bank_req_byteen (bank_req_byteen),
    .bank_req_data   (bank_req_data),
    .grant           (grant),
    .rsp_valid       (rsp_valid),
    .rsp_ready       (rsp_ready),
    .rsp_tag         (rsp_tag),
    .rsp_data        (rsp_data)
);

/* tb/cache_demux_tb.sv */
`timescale 1ns/1ps

module cache_demux_tb import cache_demux_pkg::*; ();

    localparam int NUM_TXN     = 2000;
    localparam int BURST_LEN   = 8;     // Responses per bank in the fairness burst.
    localparam int CLK_PERIOD  = 8;
    localparam int WATCHDOG_NS = (NUM_TXN + NUM_REQS * BURST_LEN) * 20 * CLK_PERIOD;
    localparam int REQ_BITS    = TAG_OUT_WIDTH + ADDR_WIDTH + 1 + DATA_SIZE + DATA_WIDTH;
    localparam int RSP_BITS    = TAG_OUT_WIDTH + DATA_WIDTH;
    localparam int UP_BITS     = TAG_IN_WIDTH + DATA_WIDTH;

    typedef logic [127:0] wide_t;

    logic                    clk;
    logic                    rst_n;
    logic                    req_valid;
    tag_in_t                 req_tag;
    addr_t                   req_addr;
    logic                    req_rw;
    byteen_t                 req_byteen;
    data_t                   req_data;
    logic                    req_ready;
    req_mask_t               bank_req_valid;
    tag_out_t [NUM_REQS-1:0] bank_req_tag;
    addr_t    [NUM_REQS-1:0] bank_req_addr;
    logic     [NUM_REQS-1:0] bank_req_rw;
    byteen_t  [NUM_REQS-1:0] bank_req_byteen;
    data_t    [NUM_REQS-1:0] bank_req_data;
    req_mask_t               bank_req_ready;
    req_mask_t               bank_rsp_valid;
    tag_out_t [NUM_REQS-1:0] bank_rsp_tag;
    data_t    [NUM_REQS-1:0] bank_rsp_data;
    req_mask_t               bank_rsp_ready;
    logic                    rsp_valid;
    tag_in_t                 rsp_tag;
    data_t                   rsp_data;
    logic                    rsp_ready;

    logic [REQ_BITS-1:0] exp_req_q  [NUM_REQS][$];   // Stripped requests per bank.
    logic [RSP_BITS-1:0] rsp_pend_q [NUM_REQS][$];   // Bank side responses.
    logic [UP_BITS-1:0]  exp_rsp_q  [NUM_REQS][$];   // Rebuilt upstream responses.

    integer    seed = 32'h3861c813;
    int        req_sent;
    int        burst_rsp;
    logic      burst;
    logic      req_fire;
    logic      rsp_fire;
    req_mask_t bank_req_fire;
    req_mask_t bank_rsp_fire;
    sel_t      last_win;
    sel_t      prev_bank;

    cache_demux uut (.*);

    always #(CLK_PERIOD / 2) clk = ~clk;

    function automatic logic chance(input int pct);
        int unsigned r;
        r = $random(seed);
        return (r % 100) < pct;
    endfunction

    function automatic sel_t sel_of(input tag_in_t tag);
        sel_t res;
        for (int j = 0; j < LOG_NUM_REQS; j++) begin
            res[j] = tag[TAG_SEL_IDX + j];
        end
        return res;
    endfunction

    // Tag bits outside the select field, packed downward.
    function automatic tag_out_t strip_sel(input tag_in_t tag);
        tag_out_t res;
        int       k;
        res = '0;
        k   = 0;
        for (int j = 0; j < TAG_IN_WIDTH; j++) begin
            if (j < TAG_SEL_IDX || j >= TAG_SEL_IDX + LOG_NUM_REQS) begin
                res[k] = tag[j];
                k++;
            end
        end
        return res;
    endfunction

    function automatic tag_in_t insert_sel(input tag_out_t tag, input sel_t sel);
        tag_in_t res;
        sel_t    s;
        int      k;
        s = sel;
        k = 0;
        for (int j = 0; j < TAG_IN_WIDTH; j++) begin
            if (j >= TAG_SEL_IDX && j < TAG_SEL_IDX + LOG_NUM_REQS) begin
                res[j] = s[0];
                s      = s >> 1;
            end else begin
                res[j] = tag[k];
                k++;
            end
        end
        return res;
    endfunction

    function automatic logic model_idle();
        logic idle;
        idle = (req_sent == NUM_TXN) && !rsp_valid && (bank_req_valid == '0);
        for (int k = 0; k < NUM_REQS; k++) begin
            idle = idle && exp_req_q[k].size() == 0 && rsp_pend_q[k].size() == 0
                   && exp_rsp_q[k].size() == 0;
        end
        return idle;
    endfunction

    task automatic fail_run(input string why);
        $display("ERROR at %0t: %s", $time, why);
        $display("TEST FAIL");
        $fatal(1, "simulation stopped on error");
    endtask

    task automatic check_eq(input string name, input wide_t exp, input wide_t act);
        assert (exp === act) else begin
            $display("CHECK FAILED at %0t: %s expected %h, got %h", $time, name, exp, act);
            $display("TEST FAIL");
            $fatal(1, "value mismatch");
        end
    endtask

    task automatic check_reset_state();
        check_eq("bank_req_valid", wide_t'(0), wide_t'(bank_req_valid));
        check_eq("rsp_valid", wide_t'(0), wide_t'(rsp_valid));
        check_eq("req_ready", wide_t'(1), wide_t'(req_ready));
    endtask

    // Valid holds until its transfer, then a new item may follow.
    task automatic drive_inputs();
        if (!req_valid || req_fire) begin
            req_valid = 1'b0;
            if (!burst && req_sent < NUM_TXN && chance(60)) begin
                req_valid  = 1'b1;
                req_tag    = tag_in_t'($random(seed));
                req_addr   = addr_t'($random(seed));
                req_rw     = chance(50);
                req_byteen = byteen_t'($random(seed));
                req_data   = data_t'($random(seed));
            end
        end
        for (int k = 0; k < NUM_REQS; k++) begin
            bank_req_ready[k] = burst ? 1'b0 : chance(70);
            if (!bank_rsp_valid[k] || bank_rsp_fire[k]) begin
                bank_rsp_valid[k] = 1'b0;
                if (rsp_pend_q[k].size() > 0 && (burst || chance(50))) begin
                    bank_rsp_valid[k] = 1'b1;
                    {bank_rsp_tag[k], bank_rsp_data[k]} = rsp_pend_q[k][0];
                end
            end
        end
        rsp_ready = burst ? 1'b1 : chance(60);
    endtask

    task automatic sample_and_check();
        req_mask_t           exp_grant;
        logic                exp_ready;
        sel_t                idx;
        sel_t                bank;
        logic [REQ_BITS-1:0] got_req;
        logic [REQ_BITS-1:0] want_req;
        logic [RSP_BITS-1:0] item;
        logic [UP_BITS-1:0]  want_up;

        req_fire      = req_valid & req_ready;
        bank_req_fire = bank_req_valid & bank_req_ready;
        bank_rsp_fire = bank_rsp_valid & bank_rsp_ready;
        rsp_fire      = rsp_valid & rsp_ready;

        // Ready while the slot is empty or its bank takes it.
        exp_ready = (bank_req_valid == '0) || (bank_req_fire != '0);
        check_eq("req_ready", wide_t'(exp_ready), wide_t'(req_ready));

        if (req_fire) begin
            bank = sel_of(req_tag);
            exp_req_q[bank].push_back({strip_sel(req_tag), req_addr, req_rw, req_byteen,
                                       req_data});
            req_sent++;
        end

        for (int k = 0; k < NUM_REQS; k++) begin
            if (bank_req_fire[k]) begin
                assert (exp_req_q[k].size() > 0) else
                    fail_run($sformatf("bank %0d received a request not routed to it", k));
                want_req = exp_req_q[k].pop_front();
                got_req  = {bank_req_tag[k], bank_req_addr[k], bank_req_rw[k],
                            bank_req_byteen[k], bank_req_data[k]};
                check_eq($sformatf("bank_req[%0d]", k), wide_t'(want_req), wide_t'(got_req));
                rsp_pend_q[k].push_back({tag_out_t'($random(seed)), data_t'($random(seed))});
            end
        end

        // Round robin from one past the last winner, only with a free slot.
        exp_grant = '0;
        if (!rsp_valid || rsp_ready) begin
            for (int s = 1; s <= NUM_REQS; s++) begin
                idx = sel_t'((int'(last_win) + s) % NUM_REQS);
                if (exp_grant == '0 && bank_rsp_valid[idx]) begin
                    exp_grant[idx] = 1'b1;
                end
            end
        end
        check_eq("bank_rsp_ready", wide_t'(exp_grant), wide_t'(bank_rsp_ready));

        for (int k = 0; k < NUM_REQS; k++) begin
            if (bank_rsp_fire[k]) begin
                item     = rsp_pend_q[k].pop_front();
                last_win = sel_t'(k);
                exp_rsp_q[k].push_back({insert_sel(item[RSP_BITS-1 -: TAG_OUT_WIDTH],
                                                   sel_t'(k)), item[DATA_WIDTH-1:0]});
            end
        end

        if (rsp_fire) begin
            bank = sel_of(rsp_tag);
            assert (exp_rsp_q[bank].size() > 0) else
                fail_run("upstream response for a bank with nothing outstanding");
            want_up = exp_rsp_q[bank].pop_front();
            check_eq("rsp_tag/rsp_data", wide_t'(want_up), wide_t'({rsp_tag, rsp_data}));
            if (burst && burst_rsp > 0) begin
                check_eq("rsp bank order", wide_t'(sel_t'(prev_bank + 1'b1)), wide_t'(bank));
            end
            prev_bank = bank;
            burst_rsp++;
        end
    endtask

    initial begin
        clk            = 1'b0;
        rst_n          = 1'b0;
        req_valid      = 1'b0;
        req_tag        = '0;
        req_addr       = '0;
        req_rw         = 1'b0;
        req_byteen     = '0;
        req_data       = '0;
        bank_req_ready = '0;
        bank_rsp_valid = '0;
        bank_rsp_tag   = '0;
        bank_rsp_data  = '0;
        rsp_ready      = 1'b0;
        req_fire       = 1'b0;
        rsp_fire       = 1'b0;
        bank_req_fire  = '0;
        bank_rsp_fire  = '0;
        last_win       = '0;
        prev_bank      = '0;
        req_sent       = 0;
        burst_rsp      = 0;
        burst          = 1'b0;

        repeat (3) begin
            @(negedge clk);
            check_reset_state();
        end
        rst_n = 1'b1;
        #1;
        check_reset_state();

        // Random traffic with stalls on every port.
        while (!model_idle()) begin
            @(negedge clk);
            drive_inputs();
            #1;
            sample_and_check();
        end

        // All banks full, client always ready.
        burst     = 1'b1;
        burst_rsp = 0;
        for (int k = 0; k < NUM_REQS; k++) begin
            repeat (BURST_LEN) begin
                rsp_pend_q[k].push_back({tag_out_t'($random(seed)), data_t'($random(seed))});
            end
        end
        while (!model_idle()) begin
            @(negedge clk);
            drive_inputs();
            #1;
            sample_and_check();
        end

        $display("TEST PASS");
        $finish;
    end

    initial begin
        #(WATCHDOG_NS);
        $display("Timeout: traffic did not finish within the time limit");
        $display("TEST FAIL");
        $fatal(1, "watchdog expired");
    end

endmodule
